//--- dv/trace_model.svh
`ifndef trace_model_svh
`define trace_model_svh

////////////////////
// Model state.
////////////////////
// Index 0 is fetch, index 4 is write-back.
logic     stage_live [num_stages];
inst_id_t stage_tag  [num_stages];
inst_id_t model_next_id;            // ID for the next fetched instruction.
cycle_t   model_cycle;              // Cycle number of the current state.

pc_t      rec_pc     [trace_depth]; // Last sample per stage and ID.
instr_t   rec_instr  [trace_depth];
word_t    rec_result [trace_depth];
word_t    rec_mem    [trace_depth];

// Expected retirement record for the cycle after the last edge.
logic     exp_valid;
inst_id_t exp_id;
cycle_t   exp_cycle;
pc_t      exp_pc;
instr_t   exp_instr;
word_t    exp_result;
word_t    exp_mem;
word_t    exp_wb;

function automatic void reset_model();
    for (int s = 0; s < num_stages; s++) begin
        stage_live[s] = 1'b0;
        stage_tag[s]  = '0;
    end
    model_next_id = '0;
    model_cycle   = '1;   // First free edge starts cycle 0.
    exp_valid     = 1'b0;
endfunction

////////////////////
// One clock edge.
////////////////////
// Returns 1 when an instruction retires in the next cycle.
function automatic logic step_model(
    input logic   ic,
    input logic   hz,
    input logic   dc,
    input pc_t    pc,
    input instr_t instr,
    input word_t  result,
    input word_t  mem_data,
    input word_t  wb
);
    int   held;     // Deepest held stage, -1 with no stall.
    logic retire;

    // Write-back content now is next cycle's retirement.
    retire = stage_live[4];
    if (retire) begin
        exp_id     = stage_tag[4];
        exp_cycle  = model_cycle;
        exp_pc     = rec_pc[stage_tag[4]];
        exp_instr  = rec_instr[stage_tag[4]];
        exp_result = rec_result[stage_tag[4]];
        exp_mem    = rec_mem[stage_tag[4]];
        exp_wb     = wb;                          // Single write-back sample.
    end

    // Live stages overwrite their entry, so the last sample wins.
    if (stage_live[0]) rec_pc[stage_tag[0]] = pc;
    if (stage_live[1]) rec_instr[stage_tag[1]] = instr;
    if (stage_live[2]) rec_result[stage_tag[2]] = result;
    if (stage_live[3]) rec_mem[stage_tag[3]] = mem_data;

    // Data cache beats hazard beats instruction cache.
    if (dc) held = 3;
    else if (hz) held = 1;
    else if (ic) held = 0;
    else held = -1;

    // Stages beyond the bubble advance, deepest first.
    for (int s = num_stages - 1; s > held + 1; s--) begin
        stage_live[s] = stage_live[s-1];
        stage_tag[s]  = stage_tag[s-1];
    end
    if (held >= 0) begin
        stage_live[held + 1] = 1'b0;   // Bubble right behind the held stages.
    end else begin
        stage_live[0] = 1'b1;
        stage_tag[0]  = model_next_id;
        model_next_id = model_next_id + 1'b1;   // Wraps at 256.
    end
    model_cycle = model_cycle + 1'b1;
    return retire;
endfunction

`endif

//--- dv/tb_pipeline_trace.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipeline_trace import trace_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     icache_stall;
    logic     hazard_stall;
    logic     dcache_stall;
    pc_t      fetch_pc;
    instr_t   decode_instr;
    word_t    execute_result;
    word_t    memory_data;
    word_t    wb_data;
    logic     retire_valid;
    inst_id_t retire_id;
    cycle_t   retire_cycle;
    pc_t      retire_pc;
    instr_t   retire_instr;
    word_t    retire_result;
    word_t    retire_mem;
    word_t    retire_wb;

    integer   seed = 32'h2ac0_8372;
    int       pass_count;
    int       fail_count;
    int       retire_count;     // DUT retirements seen so far.
    int       cycle_total;
    int       max_cycles = 1500; // Tests take about 1,100 cycles at most.
    logic     checking_on;       // Set once reset has reached the DUT.
    inst_id_t next_retire_id;
    inst_id_t first_id;
    cycle_t   first_cycle;

    `include "trace_model.svh"

    pipeline_trace i_dut (.*);

    always #20 clk = ~clk;   // 40 ns period.

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    ////////////////////
    // Model and checks.
    ////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
            checking_on = 1'b1;
        end else begin
            exp_valid = step_model(icache_stall, hazard_stall, dcache_stall, fetch_pc,
                                   decode_instr, execute_result, memory_data, wb_data);
        end
    end

    // Outputs are settled by mid-cycle.
    always @(negedge clk) begin
        if (checking_on) begin
            compare_field("retire_valid", exp_valid, retire_valid);
            if (retire_valid === 1'b1) begin
                if (exp_valid) begin
                    compare_field("retire_id", exp_id, retire_id);
                    compare_field("retire_cycle", exp_cycle, retire_cycle);
                    compare_field("retire_pc", exp_pc, retire_pc);
                    compare_field("retire_instr", exp_instr, retire_instr);
                    compare_field("retire_result", exp_result, retire_result);
                    compare_field("retire_mem", exp_mem, retire_mem);
                    compare_field("retire_wb", exp_wb, retire_wb);
                end
                if (retire_count == 0) begin
                    first_id    = retire_id;
                    first_cycle = retire_cycle;
                end
                next_retire_id = retire_count[id_w-1:0];   // No gaps, wraps past 255.
                compare_field("retire_id", next_retire_id, retire_id);
                retire_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_total++;
        if (cycle_total >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus.
    ////////////////////
    task automatic drive_cycle(input logic ic, input logic hz, input logic dc);
        @(posedge clk);
        #2;
        icache_stall   = ic;
        hazard_stall   = hz;
        dcache_stall   = dc;
        fetch_pc       = $random(seed);
        decode_instr   = $random(seed);
        execute_result = $random(seed);
        memory_data    = $random(seed);
        wb_data        = $random(seed);
    endtask

    // Mode 0 no stalls, 1 icache bursts, 2 hazard or dcache bursts, 3 random mix.
    task automatic run_stream(input int mode, input int count);
        int   target;
        int   burst;
        int   kind;
        logic ic;
        logic hz;
        logic dc;
        target = retire_count + count;
        burst  = 0;
        kind   = 0;
        while (retire_count < target) begin
            ic = 1'b0;
            hz = 1'b0;
            dc = 1'b0;
            if (mode == 3) begin
                ic = ($unsigned($random(seed)) % 6) == 0;   // Overlaps allowed.
                hz = ($unsigned($random(seed)) % 6) == 0;
                dc = ($unsigned($random(seed)) % 6) == 0;
            end else if (mode != 0 && burst > 0) begin
                burst = burst - 1;
                if (mode == 1) ic = 1'b1;
                else if (kind != 0) dc = 1'b1;
                else hz = 1'b1;
            end else if (mode != 0 && ($random(seed) & 3) == 0) begin
                burst = 1 + ($random(seed) & 3);   // 1 to 4 stall cycles.
                kind  = $random(seed) & 1;
            end
            drive_cycle(ic, hz, dc);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%s: done, %0d mismatches", name, fail_count - fails_before);
    endtask

    initial begin
        int fails_before;
        clk = 1'b0;
        rst_n = 1'b0;
        icache_stall = 1'b0;
        hazard_stall = 1'b0;
        dcache_stall = 1'b0;
        fetch_pc = '0;
        decode_instr = '0;
        execute_result = '0;
        memory_data = '0;
        wb_data = '0;
        pass_count = 0;
        fail_count = 0;
        retire_count = 0;
        cycle_total = 0;
        checking_on = 1'b0;
        exp_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        fails_before = fail_count;
        run_stream(0, 8);
        compare_field("retire_id", 32'd0, first_id);      // First retirement is ID 0.
        compare_field("retire_cycle", 32'd4, first_cycle);
        report_test("reset and first retirement", fails_before);

        fails_before = fail_count;
        run_stream(0, 40);
        report_test("stall-free stream", fails_before);

        fails_before = fail_count;
        run_stream(1, 60);
        report_test("instruction-cache stall bursts", fails_before);

        fails_before = fail_count;
        run_stream(2, 60);
        report_test("hazard and data-cache stalls", fails_before);

        fails_before = fail_count;
        run_stream(3, 300);
        report_test("random stall mix", fails_before);

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
hdl/trace_pkg.sv
hdl/stage_tracker.sv
hdl/trace_store.sv
hdl/retire_report.sv
hdl/pipeline_trace.sv
dv/tb_pipeline_trace.sv

//--- hdl/pipeline_trace.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_trace import trace_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     icache_stall,    // Holds fetch.
    input  logic     hazard_stall,    // Holds fetch and decode.
    input  logic     dcache_stall,    // Holds fetch through memory.
    input  pc_t      fetch_pc,
    input  instr_t   decode_instr,
    input  word_t    execute_result,
    input  word_t    memory_data,
    input  word_t    wb_data,
    output logic     retire_valid,
    output inst_id_t retire_id,
    output cycle_t   retire_cycle,
    output pc_t      retire_pc,
    output instr_t   retire_instr,
    output word_t    retire_result,
    output word_t    retire_mem,
    output word_t    retire_wb
);

    logic     fetch_valid;
    inst_id_t fetch_id;
    logic     decode_valid;
    inst_id_t decode_id;
    logic     execute_valid;
    inst_id_t execute_id;
    logic     memory_valid;
    inst_id_t memory_id;
    logic     wb_valid;
    inst_id_t wb_id;

    ////////////////////
    // Stage tracking.
    ////////////////////
    stage_tracker i_stage_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .icache_stall  (icache_stall),
        .hazard_stall  (hazard_stall),
        .dcache_stall  (dcache_stall),
        .fetch_valid   (fetch_valid),
        .fetch_id      (fetch_id),
        .decode_valid  (decode_valid),
        .decode_id     (decode_id),
        .execute_valid (execute_valid),
        .execute_id    (execute_id),
        .memory_valid  (memory_valid),
        .memory_id     (memory_id),
        .wb_valid      (wb_valid),
        .wb_id         (wb_id)
    );

    ////////////////////
    // Record storage.
    ////////////////////
    // All stores are read at the write-back ID.
    trace_store #(.payload_t(pc_t)) i_fetch_store (
        .clk (clk), .wr_en (fetch_valid), .wr_id (fetch_id), .wr_data (fetch_pc),
        .rd_en (wb_valid), .rd_id (wb_id), .rd_data (retire_pc)
    );

    trace_store #(.payload_t(instr_t)) i_decode_store (
        .clk (clk), .wr_en (decode_valid), .wr_id (decode_id), .wr_data (decode_instr),
        .rd_en (wb_valid), .rd_id (wb_id), .rd_data (retire_instr)
    );

    trace_store #(.payload_t(word_t)) i_execute_store (
        .clk (clk), .wr_en (execute_valid), .wr_id (execute_id), .wr_data (execute_result),
        .rd_en (wb_valid), .rd_id (wb_id), .rd_data (retire_result)
    );

    trace_store #(.payload_t(word_t)) i_memory_store (
        .clk (clk), .wr_en (memory_valid), .wr_id (memory_id), .wr_data (memory_data),
        .rd_en (wb_valid), .rd_id (wb_id), .rd_data (retire_mem)
    );

    ////////////////////
    // Write-back report.
    ////////////////////
    retire_report i_retire_report (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_valid     (wb_valid),
        .wb_id        (wb_id),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_id    (retire_id),
        .retire_cycle (retire_cycle),
        .retire_wb    (retire_wb)
    );

endmodule

`default_nettype wire

//--- hdl/retire_report.sv
`timescale 1ns/100ps
`default_nettype none

module retire_report import trace_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_valid,      // Write-back holds an instruction.
    input  inst_id_t wb_id,
    input  word_t    wb_data,       // Write-back payload this cycle.
    output logic     retire_valid,  // One-cycle strobe per instruction.
    output inst_id_t retire_id,
    output cycle_t   retire_cycle,  // Cycle the instruction sat in write-back.
    output word_t    retire_wb
);

    cycle_t cycle_cnt;   // Free-running cycle stamp.

    ////////////////////
    // Cycle counter.
    ////////////////////
    // Cycle 0 is the cycle that starts at the first edge out of
    // reset, the same cycle fetch first holds ID 0.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '1;                   // Rolls to 0 on the first free edge.
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    ////////////////////
    // Retirement.
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;          // Lines up with the store read data.
        end
    end

    // Record fields, loaded in the write-back cycle.
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_id    <= wb_id;
            retire_cycle <= cycle_cnt;
            retire_wb    <= wb_data;           // Write-back keeps a single sample.
        end
    end

    // Write-back never holds one instruction for two cycles.
    a_single_retire: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid || (retire_id != $past(retire_id))
    ) else $error("retire_report: ID %0h retired twice in a row.", retire_id);

endmodule

`default_nettype wire

//--- hdl/stage_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module stage_tracker import trace_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     icache_stall,   // Acts at fetch.
    input  logic     hazard_stall,   // Acts at decode.
    input  logic     dcache_stall,   // Acts at memory.
    output logic     fetch_valid,
    output inst_id_t fetch_id,
    output logic     decode_valid,
    output inst_id_t decode_id,
    output logic     execute_valid,
    output inst_id_t execute_id,
    output logic     memory_valid,
    output inst_id_t memory_id,
    output logic     wb_valid,
    output inst_id_t wb_id
);

    inst_id_t next_id;        // ID handed to the next fetched instruction.
    logic     hold_fetch;     // Any stall freezes fetch.
    logic     hold_decode;    // Hazard or data-cache stall.
    logic     hold_memory;    // Data-cache stall freezes execute and memory.

    ////////////////////
    // Stall decode.
    ////////////////////
    // A stall at stage k holds every stage up to k. The stage after
    // the deepest held one takes a bubble, deeper stages advance.
    assign hold_fetch  = icache_stall | hazard_stall | dcache_stall;
    assign hold_decode = hazard_stall | dcache_stall;
    assign hold_memory = dcache_stall;

    ////////////////////
    // Stage registers.
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_id       <= '0;
            fetch_valid   <= 1'b0;
            fetch_id      <= '0;
            decode_valid  <= 1'b0;
            decode_id     <= '0;
            execute_valid <= 1'b0;
            execute_id    <= '0;
            memory_valid  <= 1'b0;
            memory_id     <= '0;
            wb_valid      <= 1'b0;
            wb_id         <= '0;
        end else begin
            if (!hold_fetch) begin
                fetch_valid <= 1'b1;             // New instruction every free cycle.
                fetch_id    <= next_id;
                next_id     <= next_id + 1'b1;   // Wraps at 256.
            end

            if (!hold_decode) begin
                decode_valid <= fetch_valid & ~hold_fetch;  // Bubble on icache stall.
                decode_id    <= fetch_id;
            end

            if (!hold_memory) begin
                execute_valid <= decode_valid & ~hold_decode;  // Bubble on hazard.
                execute_id    <= decode_id;
                memory_valid  <= execute_valid;
                memory_id     <= execute_id;
            end

            wb_valid <= memory_valid & ~hold_memory;  // Bubble on dcache stall.
            wb_id    <= memory_id;
        end
    end

    ////////////////////
    // Checks.
    ////////////////////
    logic [num_stages-1:0] stage_valid;
    inst_id_t              stage_id [num_stages];
    logic                  ids_unique;

    assign stage_valid = {wb_valid, memory_valid, execute_valid, decode_valid, fetch_valid};
    assign stage_id[0] = fetch_id;
    assign stage_id[1] = decode_id;
    assign stage_id[2] = execute_id;
    assign stage_id[3] = memory_id;
    assign stage_id[4] = wb_id;

    // Pairwise compare of all valid stages.
    always_comb begin
        ids_unique = 1'b1;
        for (int i = 0; i < num_stages; i++) begin
            for (int j = i + 1; j < num_stages; j++) begin
                if (stage_valid[i] && stage_valid[j] && stage_id[i] == stage_id[j]) begin
                    ids_unique = 1'b0;
                end
            end
        end
    end

    // Two live stages must never carry the same instruction.
    a_ids_unique: assert property (@(posedge clk) disable iff (!rst_n) ids_unique)
        else $error("stage_tracker: duplicate instruction ID in pipeline.");

endmodule

`default_nettype wire

//--- hdl/trace_pkg.sv
`default_nettype none

package trace_pkg;

    ////////////////////
    // Widths and depth.
    ////////////////////
    localparam int id_w        = 8;          // Instruction ID width.
    localparam int trace_depth = 2 ** id_w;  // One record entry per possible ID.
    localparam int num_stages  = 5;          // Fetch, decode, execute, memory, write-back.

    localparam int pc_w    = 16;             // Fetch address width.
    localparam int word_w  = 32;             // Instruction and data word width.
    localparam int cycle_w = 32;             // Cycle stamp width.

    ////////////////////
    // Payload types.
    ////////////////////
    // IDs wrap after 255, so only the pipeline depth must stay unique.
    typedef logic [id_w-1:0]    inst_id_t;

    typedef logic [pc_w-1:0]    pc_t;     // Fetch payload.
    typedef logic [word_w-1:0]  instr_t;  // Decode payload.
    typedef logic [word_w-1:0]  word_t;   // Execute, memory and write-back payload.
    typedef logic [cycle_w-1:0] cycle_t;  // Cycles since reset.

endpackage

`default_nettype wire

//--- hdl/trace_store.sv
`timescale 1ns/100ps
`default_nettype none

module trace_store import trace_pkg::*; #(
    parameter type payload_t = word_t   // Payload kept per instruction.
) (
    input  logic     clk,
    input  logic     wr_en,     // Stage holds a valid instruction.
    input  inst_id_t wr_id,     // ID currently in the stage.
    input  payload_t wr_data,   // Stage payload this cycle.
    input  logic     rd_en,     // Write-back holds a valid instruction.
    input  inst_id_t rd_id,     // ID in write-back.
    output payload_t rd_data    // Record, one cycle after rd_en.
);

    payload_t mem [trace_depth];   // One entry per instruction ID.

    ////////////////////
    // Write port.
    ////////////////////
    // A held stage writes its entry again each cycle, so the
    // record keeps the last sample the stage saw.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_id] <= wr_data;
        end
    end

    ////////////////////
    // Read port.
    ////////////////////
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_id];   // Registered read.
        end
    end

    // The record must not pick up an undriven stage payload.
    a_wr_data_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_data))
        else $error("trace_store: unknown write data for ID %0h.", wr_id);

endmodule

`default_nettype wire
